//--- verilog/csi_consts.svh
`ifndef CSI_CONSTS_SVH
`define CSI_CONSTS_SVH

// Physical D-PHY data lanes on the port
`define CSI_NUM_LANES 4

// Frame start and frame end short packet codes
`define CSI_DT_FS 6'h00
`define CSI_DT_FE 6'h01

// Data types up to this value are short packets
`define CSI_DT_SHORT_MAX 6'h0F

// Entries in each output FIFO
`define CSI_FIFO_DEPTH 8

// Credits each output channel starts with
`define CSI_OUT_CREDITS 4

`endif

//--- verilog/csi_pkt_pkg.sv
package csi_pkt_pkg;

    // Virtual channel id, top two bits of the data identifier
    typedef logic [1:0] csi_vc_t;

    // Data type code, low six bits of the data identifier
    typedef logic [5:0] csi_dt_t;

    // Packet header as it sits in the first gathered word
    // Byte 0 is the data identifier, bytes 1 and 2 the word count
    // (low byte first), byte 3 the ECC
    typedef struct packed {
        logic [7:0]  ecc;   // Read off the wire and not checked
        logic [15:0] wc;    // Payload bytes, or frame number on FS/FE
        csi_vc_t     vc;
        csi_dt_t     dt;
    } csi_header_t;

endpackage

//--- verilog/csi_stream_pkg.sv
package csi_stream_pkg;

    // Number of D-PHY lanes carrying data
    typedef enum logic [1:0] {
        LANES_1 = 2'd0,
        LANES_2 = 2'd1,
        LANES_4 = 2'd2
    } lane_cnt_e;

    // Static receiver setup, must not change while a burst is running
    typedef struct packed {
        lane_cnt_e            lanes;    // Active lane count
        csi_pkt_pkg::csi_vc_t vc;       // VC whose payload and frame events are kept
        csi_pkt_pkg::csi_dt_t dt;       // Long packet type that is forwarded
    } csi_cfg_t;

    // Gathered word between lane merge and parser
    typedef struct packed {
        logic        valid;     // One cycle pulse per word
        logic        sob;       // First word of a burst, holds the header
        logic [31:0] data;      // First wire byte in bits 7:0
        logic [2:0]  nbytes;    // 1 to 4, less than 4 only on burst flush
    } csi_word_t;

    // Payload beat on the pixel channel
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  keep;      // Byte valid, bit 0 for bits 7:0
        logic        last;      // Final beat of the packet
    } csi_beat_t;

    // Frame start or end notification
    typedef struct packed {
        logic                 fe;           // 1 frame end, 0 frame start
        csi_pkt_pkg::csi_vc_t vc;
        logic [15:0]          frame_num;
    } csi_event_t;

endpackage

//--- verilog/csi_lane_merge.sv
`timescale 1ns/1ps
`include "csi_consts.svh"

module csi_lane_merge (
    input  logic                      rx_byte_clk_hs,
    input  logic                      reset_n_i,
    input  csi_stream_pkg::csi_cfg_t  cfg_i,
    input  logic                      rx_valid_i [`CSI_NUM_LANES],  // Per lane byte valid
    input  logic [7:0]                rx_data_i  [`CSI_NUM_LANES],  // Lane i holds i-th byte
    output csi_stream_pkg::csi_word_t word_o
);
    import csi_stream_pkg::*;

    logic [2:0]  lane_n;    // Lanes in use from cfg
    logic [2:0]  take;      // Bytes delivered this cycle
    logic [2:0]  fill_q;    // Bytes already held in the gather register
    logic [2:0]  fill_d;
    logic [31:0] gather_q;
    logic [31:0] gather_d;
    logic        first_q;   // Next word out is the burst's first

    always_comb begin
        lane_n = (cfg_i.lanes == LANES_4) ? 3'd4 :
                 (cfg_i.lanes == LANES_2) ? 3'd2 : 3'd1;
        // Count valid lanes from lane 0 upward, a gap ends the run
        take = '0;
        for (int i = 0; i < `CSI_NUM_LANES; i++) begin
            if (i < int'(lane_n) && rx_valid_i[i] && int'(take) == i)
                take = 3'(i + 1);
        end
        // Drop new bytes in right above the ones already held
        gather_d = gather_q;
        for (int b = 0; b < 4; b++) begin
            if (b >= int'(fill_q) && b < int'(fill_q) + int'(take))
                gather_d[b*8 +: 8] = rx_data_i[b - int'(fill_q)];
        end
        fill_d = fill_q + take;
    end

    always_ff @(posedge rx_byte_clk_hs) begin
        gather_q <= gather_d;  // Stale bytes above fill_q are never used
    end

    always_ff @(posedge rx_byte_clk_hs or negedge reset_n_i) begin
        if (!reset_n_i) begin
            fill_q  <= '0;
            first_q <= 1'b1;
            word_o  <= '0;
        end else begin
            word_o.valid <= 1'b0;                   // Pulse only
            if (rx_valid_i[0]) begin
                if (fill_d == 3'd4) begin           // Word complete, send it
                    word_o  <= '{valid: 1'b1, sob: first_q, data: gather_d, nbytes: 3'd4};
                    fill_q  <= '0;
                    first_q <= 1'b0;
                end else begin
                    fill_q <= fill_d;
                end
            end else begin
                if (fill_q != '0)                   // Burst ended mid word, flush the rest
                    word_o <= '{valid: 1'b1, sob: first_q, data: gather_q, nbytes: fill_q};
                fill_q  <= '0;
                first_q <= 1'b1;                    // Rearm for the next header
            end
        end
    end

endmodule

//--- verilog/csi_packet_parser.sv
`timescale 1ns/1ps
`include "csi_consts.svh"

module csi_packet_parser (
    input  logic                       rx_byte_clk_hs,
    input  logic                       reset_n_i,
    input  csi_stream_pkg::csi_cfg_t   cfg_i,
    input  csi_stream_pkg::csi_word_t  word_i,
    output csi_stream_pkg::csi_beat_t  beat_o,
    output logic                       beat_push_o,    // Payload FIFO write
    output csi_stream_pkg::csi_event_t event_o,
    output logic                       event_push_o,   // Event FIFO write
    output logic                       frame_valid_o,  // Between FS and FE of selected VC
    output logic [15:0]                frame_num_o     // Number from the last FS
);
    import csi_pkt_pkg::*;
    import csi_stream_pkg::*;

    csi_header_t hdr;
    logic        is_hdr;       // Header word of a burst
    logic        is_short;
    logic        vc_hit;
    logic        is_fs;
    logic        is_fe;
    logic        is_pay;       // Word inside a long packet body
    logic        pay_last;
    logic [2:0]  pay_n;        // Payload bytes in this word
    logic [3:0]  pay_keep;
    logic        in_pkt_q;     // Long packet body still arriving
    logic        pass_q;       // Current long packet matches cfg
    logic [15:0] remain_q;     // Payload bytes still to come

    assign hdr      = csi_header_t'(word_i.data);
    assign is_hdr   = word_i.valid && word_i.sob;
    assign is_short = hdr.dt <= `CSI_DT_SHORT_MAX;
    assign vc_hit   = hdr.vc == cfg_i.vc;
    // Only frame start/end of our VC count, other short packets fall through
    assign is_fs    = is_hdr && is_short && vc_hit && hdr.dt == `CSI_DT_FS;
    assign is_fe    = is_hdr && is_short && vc_hit && hdr.dt == `CSI_DT_FE;
    assign is_pay   = word_i.valid && !word_i.sob && in_pkt_q;

    always_comb begin
        pay_last = remain_q <= 16'(word_i.nbytes);          // Body ends in this word
        pay_n    = pay_last ? remain_q[2:0] : word_i.nbytes;
        case (pay_n)                                        // Trailing CRC bytes masked off
            3'd1:    pay_keep = 4'b0001;
            3'd2:    pay_keep = 4'b0011;
            3'd3:    pay_keep = 4'b0111;
            default: pay_keep = 4'b1111;
        endcase
    end

    // Packet tracking and output strobes
    always_ff @(posedge rx_byte_clk_hs or negedge reset_n_i) begin
        if (!reset_n_i) begin
            in_pkt_q      <= 1'b0;
            pass_q        <= 1'b0;
            remain_q      <= '0;
            beat_push_o   <= 1'b0;
            event_push_o  <= 1'b0;
            frame_valid_o <= 1'b0;
            frame_num_o   <= '0;
        end else begin
            beat_push_o  <= is_pay && pass_q;
            event_push_o <= is_fs || is_fe;

            if (is_fs) begin
                frame_valid_o <= 1'b1;
                frame_num_o   <= hdr.wc;    // FS word count carries the frame number
            end else if (is_fe) begin
                frame_valid_o <= 1'b0;
            end

            if (is_hdr) begin
                // Zero length long packet has no body to wait for
                in_pkt_q <= !is_short && hdr.wc != '0;
                pass_q   <= !is_short && vc_hit && hdr.dt == cfg_i.dt;
                remain_q <= hdr.wc;
            end else if (is_pay) begin
                remain_q <= remain_q - 16'(pay_n);
                if (pay_last)
                    in_pkt_q <= 1'b0;       // Words after this are CRC, ignored
            end
        end
    end

    // Output payload, qualified by the push strobes
    always_ff @(posedge rx_byte_clk_hs) begin
        if (is_pay) begin
            beat_o.data <= word_i.data;
            beat_o.keep <= pay_keep;
            beat_o.last <= pay_last;
        end
        if (is_hdr) begin
            event_o.fe        <= hdr.dt == `CSI_DT_FE;
            event_o.vc        <= hdr.vc;
            event_o.frame_num <= hdr.wc;
        end
    end

endmodule

//--- verilog/csi_credit_fifo.sv
`timescale 1ns/1ps
`include "csi_consts.svh"

module csi_credit_fifo #(
    parameter type item_t = logic
) (
    input  logic  rx_byte_clk_hs,
    input  logic  reset_n_i,
    input  logic  push_i,
    input  item_t data_i,
    input  logic  credit_i,     // One credit back per high cycle
    output item_t data_o,
    output logic  valid_o,      // One item per pulse
    output logic  overflow_o    // Sticky, a push was lost
);
    localparam int DEPTH = `CSI_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRD_W = $clog2(`CSI_OUT_CREDITS + 1);

    item_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CRD_W-1:0] credit_q;     // Items the sink can still take
    logic             full;
    logic             push_ok;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full    = count_q == CNT_W'(DEPTH);
    assign push_ok = push_i && !full;                   // Upstream never waits
    assign pop     = count_q != '0 && credit_q != '0;

    always_ff @(posedge rx_byte_clk_hs or negedge reset_n_i) begin
        if (!reset_n_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            credit_q   <= CRD_W'(`CSI_OUT_CREDITS);
            valid_o    <= 1'b0;
            overflow_o <= 1'b0;
        end else begin
            if (push_ok) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (pop)     rd_ptr_q <= ptr_inc(rd_ptr_q);
            count_q  <= count_q + CNT_W'(push_ok) - CNT_W'(pop);
            credit_q <= credit_q - CRD_W'(pop) + CRD_W'(credit_i);
            valid_o  <= pop;
            if (push_i && full)
                overflow_o <= 1'b1;
        end
    end

    always_ff @(posedge rx_byte_clk_hs) begin
        if (push_ok) mem[wr_ptr_q] <= data_i;
        if (pop)     data_o <= mem[rd_ptr_q];   // Held until the next pop
    end

endmodule

//--- verilog/csi_rx_top.sv
`timescale 1ns/1ps
`include "csi_consts.svh"

module csi_rx_top (
    input  logic                       rx_byte_clk_hs,
    input  logic                       reset_n_i,
    input  csi_stream_pkg::csi_cfg_t   cfg_i,
    input  logic                       rx_valid_hs_i [`CSI_NUM_LANES],   // From the D-PHY
    input  logic [7:0]                 rx_data_hs_i  [`CSI_NUM_LANES],
    input  logic                       pix_credit_i,
    input  logic                       evt_credit_i,
    output csi_stream_pkg::csi_beat_t  pix_beat_o,
    output logic                       pix_valid_o,
    output logic                       pix_overflow_o,
    output csi_stream_pkg::csi_event_t evt_o,
    output logic                       evt_valid_o,
    output logic                       evt_overflow_o,
    output logic                       frame_valid_o,
    output logic [15:0]                frame_num_o
);
    import csi_stream_pkg::*;

    csi_word_t  word;       // Merged lane bytes
    csi_beat_t  beat;
    logic       beat_push;
    csi_event_t evt;
    logic       evt_push;

    csi_lane_merge u_lane_merge (
        .rx_byte_clk_hs (rx_byte_clk_hs),
        .reset_n_i      (reset_n_i),
        .cfg_i          (cfg_i),
        .rx_valid_i     (rx_valid_hs_i),
        .rx_data_i      (rx_data_hs_i),
        .word_o         (word)
    );

    csi_packet_parser u_parser (
        .rx_byte_clk_hs (rx_byte_clk_hs),
        .reset_n_i      (reset_n_i),
        .cfg_i          (cfg_i),
        .word_i         (word),
        .beat_o         (beat),
        .beat_push_o    (beat_push),
        .event_o        (evt),
        .event_push_o   (evt_push),
        .frame_valid_o  (frame_valid_o),
        .frame_num_o    (frame_num_o)
    );

    // Pixel payload channel
    csi_credit_fifo #(.item_t(csi_beat_t)) u_pix_fifo (
        .rx_byte_clk_hs (rx_byte_clk_hs),
        .reset_n_i      (reset_n_i),
        .push_i         (beat_push),
        .data_i         (beat),
        .credit_i       (pix_credit_i),
        .data_o         (pix_beat_o),
        .valid_o        (pix_valid_o),
        .overflow_o     (pix_overflow_o)
    );

    // Frame event channel
    csi_credit_fifo #(.item_t(csi_event_t)) u_evt_fifo (
        .rx_byte_clk_hs (rx_byte_clk_hs),
        .reset_n_i      (reset_n_i),
        .push_i         (evt_push),
        .data_i         (evt),
        .credit_i       (evt_credit_i),
        .data_o         (evt_o),
        .valid_o        (evt_valid_o),
        .overflow_o     (evt_overflow_o)
    );

endmodule

//--- tb/csi_rx_tb_vectors.svh
`ifndef CSI_RX_TB_VECTORS_SVH
`define CSI_RX_TB_VECTORS_SVH

// Test row columns: name, lane mode, filter VC, filter DT, packet count,
// credit hold cycles (0 returns credits at once), expected pix overflow
// Packet columns: VC, DT, word count (frame number on FS/FE), long flag

typedef struct packed {
    logic [1:0]  vc;
    logic [5:0]  dt;
    logic [15:0] wc;
    logic        is_long;
} pkt_row_t;

typedef struct packed {
    lane_cnt_e   lanes;
    logic [1:0]  vc;
    logic [5:0]  dt;
    logic [2:0]  npkt;
    logic [15:0] hold;
    logic        exp_ovf;
} test_row_t;

localparam int NUM_TESTS = 7;
localparam int MAX_PKTS  = 7;

string     test_name [NUM_TESTS];
test_row_t test_row  [NUM_TESTS];
pkt_row_t  test_pkt  [NUM_TESTS][MAX_PKTS];

function automatic void set_test(input int t, input string name, input lane_cnt_e lanes,
                                 input logic [1:0] vc, input logic [5:0] dt,
                                 input logic [2:0] npkt, input logic [15:0] hold,
                                 input logic exp_ovf);
    test_name[t] = name;
    test_row[t]  = '{lanes: lanes, vc: vc, dt: dt, npkt: npkt, hold: hold, exp_ovf: exp_ovf};
endfunction

function automatic void set_pkt(input int t, input int i, input logic [1:0] vc,
                                input logic [5:0] dt, input logic [15:0] wc, input logic lng);
    test_pkt[t][i] = '{vc: vc, dt: dt, wc: wc, is_long: lng};
endfunction

function automatic void load_tests();
    set_test(0, "long_4lane", LANES_4, 2'd0, 6'h2A, 3'd1, 16'd0, 1'b0);
    set_pkt(0, 0, 2'd0, 6'h2A, 16'd22, 1'b1);       // Last beat keeps 2 bytes
    set_test(1, "filter_vc_dt", LANES_4, 2'd1, 6'h2B, 3'd3, 16'd0, 1'b0);
    set_pkt(1, 0, 2'd0, 6'h2B, 16'd12, 1'b1);       // Wrong VC
    set_pkt(1, 1, 2'd1, 6'h2A, 16'd10, 1'b1);       // Wrong DT
    set_pkt(1, 2, 2'd1, 6'h2B, 16'd9, 1'b1);
    set_test(2, "frame_events", LANES_4, 2'd2, 6'h2A, 3'd4, 16'd0, 1'b0);
    set_pkt(2, 0, 2'd2, `CSI_DT_FS, 16'h0123, 1'b0);
    set_pkt(2, 1, 2'd1, `CSI_DT_FS, 16'h0007, 1'b0);   // Other VC, ignored
    set_pkt(2, 2, 2'd2, 6'h2A, 16'd8, 1'b1);
    set_pkt(2, 3, 2'd2, `CSI_DT_FE, 16'h0123, 1'b0);
    set_test(3, "long_2lane", LANES_2, 2'd0, 6'h2A, 3'd1, 16'd0, 1'b0);
    set_pkt(3, 0, 2'd0, 6'h2A, 16'd22, 1'b1);
    set_test(4, "long_1lane", LANES_1, 2'd0, 6'h2A, 3'd1, 16'd0, 1'b0);
    set_pkt(4, 0, 2'd0, 6'h2A, 16'd22, 1'b1);
    set_test(5, "credit_hold", LANES_4, 2'd0, 6'h2A, 3'd7, 16'd64, 1'b0);
    set_pkt(5, 0, 2'd0, `CSI_DT_FS, 16'h0042, 1'b0);   // Six events, two more than credits
    set_pkt(5, 1, 2'd0, `CSI_DT_FE, 16'h0042, 1'b0);
    set_pkt(5, 2, 2'd0, `CSI_DT_FS, 16'h0043, 1'b0);
    set_pkt(5, 3, 2'd0, `CSI_DT_FE, 16'h0043, 1'b0);
    set_pkt(5, 4, 2'd0, `CSI_DT_FS, 16'h0044, 1'b0);
    set_pkt(5, 5, 2'd0, 6'h2A, 16'd40, 1'b1);       // 10 beats, backlog fits
    set_pkt(5, 6, 2'd0, `CSI_DT_FE, 16'h0044, 1'b0);
    set_test(6, "pix_overflow", LANES_4, 2'd0, 6'h2A, 3'd1, 16'd40, 1'b1);
    set_pkt(6, 0, 2'd0, 6'h2A, 16'd80, 1'b1);       // 20 beats, more than FIFO plus credits
endfunction

`endif

//--- tb/csi_rx_tb.sv
`timescale 1ns/1ps
`include "csi_consts.svh"

module csi_rx_tb;
    import csi_stream_pkg::*;

    `include "csi_rx_tb_vectors.svh"

    logic       rx_byte_clk_hs;
    logic       reset_n_i;
    csi_cfg_t   cfg;
    logic       rx_valid [`CSI_NUM_LANES];
    logic [7:0] rx_data  [`CSI_NUM_LANES];
    logic       pix_credit;
    logic       evt_credit;
    csi_beat_t  pix_beat;
    logic       pix_valid;
    logic       pix_overflow;
    csi_event_t evt;
    logic       evt_valid;
    logic       evt_overflow;
    logic       frame_valid;
    logic [15:0] frame_num;

    csi_beat_t  exp_beats [$];      // Scoreboard queues
    csi_event_t exp_evts  [$];
    int         seed;
    int         errs;
    int         fails;
    int         cyc;
    int         limit = 1000000;
    int         pix_cnt;            // Items seen in the current test
    int         evt_cnt;
    int         pix_held;           // Items seen while credits were withheld
    int         evt_held;
    int         pix_owed;           // Credits the sink still has to return
    int         evt_owed;
    logic       hold_q;
    logic       exp_fv;             // Frame state model
    logic [15:0] exp_fnum;
    string      cur_name;

    csi_rx_top dut (
        .rx_byte_clk_hs (rx_byte_clk_hs),
        .reset_n_i      (reset_n_i),
        .cfg_i          (cfg),
        .rx_valid_hs_i  (rx_valid),
        .rx_data_hs_i   (rx_data),
        .pix_credit_i   (pix_credit),
        .evt_credit_i   (evt_credit),
        .pix_beat_o     (pix_beat),
        .pix_valid_o    (pix_valid),
        .pix_overflow_o (pix_overflow),
        .evt_o          (evt),
        .evt_valid_o    (evt_valid),
        .evt_overflow_o (evt_overflow),
        .frame_valid_o  (frame_valid),
        .frame_num_o    (frame_num)
    );

    always #5 rx_byte_clk_hs = ~rx_byte_clk_hs;

    // Cycle count and hang guard
    always @(posedge rx_byte_clk_hs) begin
        cyc <= cyc + 1;
        if (cyc >= limit) begin
            $display("timeout after %0d cycles in %s, outputs never finished", cyc, cur_name);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Pixel sink: scoreboard and credit return
    always @(posedge rx_byte_clk_hs) begin
        csi_beat_t exp_b;
        csi_beat_t got_b;
        if (!reset_n_i) begin
            pix_owed = 0;
            pix_credit <= 1'b0;
        end else begin
            if (pix_valid) begin
                pix_cnt++;
                pix_owed++;
                if (hold_q)
                    pix_held++;
                assert (exp_beats.size() != 0) else begin
                    $display("%s: payload beat arrived with none expected", cur_name);
                    errs++;
                end
                if (exp_beats.size() != 0) begin
                    exp_b = exp_beats.pop_front();
                    got_b = pix_beat;
                    for (int j = 0; j < 4; j++)     // CRC bytes in masked lanes are don't care
                        if (!exp_b.keep[j])
                            got_b.data[j*8 +: 8] = 8'h00;
                    assert (got_b == exp_b) else begin
                        $display("mismatch %s beat expected %h actual %h", cur_name, exp_b, got_b);
                        errs++;
                    end
                end
            end
            if (!hold_q && pix_owed > 0) begin
                pix_credit <= 1'b1;
                pix_owed--;
            end else
                pix_credit <= 1'b0;
        end
    end

    // Event sink
    always @(posedge rx_byte_clk_hs) begin
        csi_event_t exp_e;
        if (!reset_n_i) begin
            evt_owed = 0;
            evt_credit <= 1'b0;
        end else begin
            if (evt_valid) begin
                evt_cnt++;
                evt_owed++;
                if (hold_q)
                    evt_held++;
                assert (exp_evts.size() != 0) else begin
                    $display("%s: frame event arrived with none expected", cur_name);
                    errs++;
                end
                if (exp_evts.size() != 0) begin
                    exp_e = exp_evts.pop_front();
                    assert (evt == exp_e) else begin
                        $display("mismatch %s event expected %h actual %h", cur_name, exp_e, evt);
                        errs++;
                    end
                end
            end
            if (!hold_q && evt_owed > 0) begin
                evt_credit <= 1'b1;
                evt_owed--;
            end else
                evt_credit <= 1'b0;
        end
    end

    // Serialize one packet over nl lanes and update the expected model
    task automatic send_packet(input pkt_row_t p, input int nl);
        logic [7:0] q   [$];
        logic [7:0] pay [$];
        logic [7:0] b;
        csi_beat_t  eb;
        q.push_back({p.vc, p.dt});
        q.push_back(p.wc[7:0]);             // Word count, low byte first
        q.push_back(p.wc[15:8]);
        q.push_back(8'h00);                 // ECC, not checked
        if (p.is_long) begin
            for (int k = 0; k < int'(p.wc); k++) begin
                b = 8'($random(seed));
                q.push_back(b);
                pay.push_back(b);
            end
            q.push_back(8'hC3);             // Dummy CRC
            q.push_back(8'h5A);
            if (p.vc == cfg.vc && p.dt == cfg.dt) begin
                for (int k = 0; k < int'(p.wc); k += 4) begin
                    eb = '0;
                    for (int j = 0; j < 4; j++)
                        if (k + j < int'(p.wc)) begin
                            eb.data[j*8 +: 8] = pay[k+j];
                            eb.keep[j] = 1'b1;
                        end
                    eb.last = (k + 4 >= int'(p.wc));
                    exp_beats.push_back(eb);
                end
            end
        end else if (p.vc == cfg.vc && (p.dt == `CSI_DT_FS || p.dt == `CSI_DT_FE)) begin
            exp_evts.push_back('{fe: p.dt == `CSI_DT_FE, vc: p.vc, frame_num: p.wc});
            exp_fv = (p.dt == `CSI_DT_FS);
            if (p.dt == `CSI_DT_FS)
                exp_fnum = p.wc;
        end
        while (q.size() > 0) begin
            @(posedge rx_byte_clk_hs);
            for (int i = 0; i < `CSI_NUM_LANES; i++) begin
                if (i < nl && q.size() > 0) begin
                    rx_valid[i] <= 1'b1;
                    rx_data[i]  <= q.pop_front();
                end else begin
                    rx_valid[i] <= 1'b0;
                    rx_data[i]  <= 8'h00;
                end
            end
        end
        @(posedge rx_byte_clk_hs);
        for (int i = 0; i < `CSI_NUM_LANES; i++)
            rx_valid[i] <= 1'b0;            // Burst end
        repeat (4) @(posedge rx_byte_clk_hs);  // Inter packet gap, lets the parser settle
    endtask

    initial begin
        int nl;
        int start_cyc;
        int errs_before;
        int total;
        int bytes;
        rx_byte_clk_hs = 1'b0;
        reset_n_i      = 1'b0;
        cfg            = '0;
        pix_credit     = 1'b0;
        evt_credit     = 1'b0;
        hold_q         = 1'b0;
        cyc            = 0;
        errs           = 0;
        fails          = 0;
        for (int i = 0; i < `CSI_NUM_LANES; i++) begin
            rx_valid[i] = 1'b0;
            rx_data[i]  = 8'h00;
        end
        load_tests();
        total = 200;                        // Margin
        for (int t = 0; t < NUM_TESTS; t++) begin
            total += 40 + int'(test_row[t].hold);
            for (int i = 0; i < int'(test_row[t].npkt); i++) begin
                // Header only on short packets, word count is a frame number there
                bytes = test_pkt[t][i].is_long ? int'(test_pkt[t][i].wc) + 6 : 4;
                total += 4 * (bytes + 8);
            end
        end
        limit = total;

        for (int t = 0; t < NUM_TESTS; t++) begin
            cur_name    = test_name[t];
            errs_before = errs;
            seed        = 32'h2c0fe15f;     // Same payload for equal rows
            exp_fv      = 1'b0;
            exp_fnum    = '0;
            nl = (test_row[t].lanes == LANES_4) ? 4 : (test_row[t].lanes == LANES_2) ? 2 : 1;
            @(posedge rx_byte_clk_hs);
            reset_n_i <= 1'b0;
            cfg       <= '{lanes: test_row[t].lanes, vc: test_row[t].vc, dt: test_row[t].dt};
            hold_q    <= (test_row[t].hold != '0);
            repeat (16) @(posedge rx_byte_clk_hs);
            pix_cnt  = 0;
            evt_cnt  = 0;
            pix_held = 0;
            evt_held = 0;
            reset_n_i <= 1'b1;
            start_cyc = cyc;
            for (int i = 0; i < int'(test_row[t].npkt); i++) begin
                send_packet(test_pkt[t][i], nl);
                assert (frame_valid == exp_fv) else begin
                    $display("mismatch %s frame_valid expected %b actual %b",
                             cur_name, exp_fv, frame_valid);
                    errs++;
                end
                assert (!exp_fv || frame_num == exp_fnum) else begin
                    $display("mismatch %s frame_num expected %h actual %h",
                             cur_name, exp_fnum, frame_num);
                    errs++;
                end
            end
            while (cyc - start_cyc < int'(test_row[t].hold))
                @(posedge rx_byte_clk_hs);
            hold_q <= 1'b0;                 // Sink starts returning credits
            // Wait for every expected item, or the full backlog when overflow drops the tail
            while (exp_evts.size() != 0 ||
                   (exp_beats.size() != 0 && !(test_row[t].exp_ovf &&
                    pix_cnt >= `CSI_FIFO_DEPTH + `CSI_OUT_CREDITS)))
                @(posedge rx_byte_clk_hs);
            assert (pix_held <= `CSI_OUT_CREDITS && evt_held <= `CSI_OUT_CREDITS) else begin
                $display("%s: more items sent than credits while held (%0d pix, %0d evt)",
                         cur_name, pix_held, evt_held);
                errs++;
            end
            assert (pix_overflow == test_row[t].exp_ovf) else begin
                $display("mismatch %s pix_overflow expected %b actual %b",
                         cur_name, test_row[t].exp_ovf, pix_overflow);
                errs++;
            end
            assert (!evt_overflow) else begin
                $display("%s: event FIFO overflowed", cur_name);
                errs++;
            end
            exp_beats.delete();
            if (errs != errs_before)
                fails++;
            $display("%s: %0d beats, %0d events, %s", cur_name, pix_cnt, evt_cnt,
                     (errs == errs_before) ? "ok" : "failed");
        end
        $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, fails, errs);
        if (errs == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- cam_rx.f
+incdir+verilog
+incdir+tb
verilog/csi_pkt_pkg.sv
verilog/csi_stream_pkg.sv
verilog/csi_lane_merge.sv
verilog/csi_packet_parser.sv
verilog/csi_credit_fifo.sv
verilog/csi_rx_top.sv
tb/csi_rx_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the CSI-2 receiver testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f cam_rx.f --top-module csi_rx_tb -o csi_rx_sim \
    && ./obj_dir/csi_rx_sim > sim.log 2>&1

cat sim.log 2> /dev/null
grep -q "RESULT: PASS" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
